/* common/st_adapt_pkg.sv */
//--------------------------------------------------------------------------
// streaming width adapter shared definitions
// widths, vector types and the half-select state encoding
//--------------------------------------------------------------------------

package st_adapt_pkg;

   //-----------------------------------------------------------------------
   // widths
   //-----------------------------------------------------------------------

   // input beat, eight bytes
   localparam int IN_W = 64;
   // output word, four bytes
   localparam int OUT_W = 32;

   // unused byte counts on the last beat / word
   localparam int IN_EMPTY_W = 3;
   localparam int OUT_EMPTY_W = 2;

   // bytes per output word
   // a last beat with at least this many empty bytes ends on the upper word
   localparam int HALF_BYTES = 4;

   //-----------------------------------------------------------------------
   // types
   //-----------------------------------------------------------------------

   typedef logic [IN_W-1:0] beat_t;
   typedef logic [OUT_W-1:0] word_t;
   typedef logic [IN_EMPTY_W-1:0] in_empty_t;
   typedef logic [OUT_EMPTY_W-1:0] out_empty_t;

   // which half of the held beat goes out next
   typedef enum logic {
      HALF_UPPER = 1'b0,
      HALF_LOWER = 1'b1
   } half_e;

endpackage

/* st_tx_64_to_32/st_in_stage.sv */
//--------------------------------------------------------------------------
// input register stage of the 64 to 32 bit adapter
// holds one input beat until the half-select FSM has used it up
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module st_in_stage (
   input  logic                   clk,
   input  logic                   reset_n,
   // upstream streaming side
   input  logic                   in_valid,
   output logic                   in_ready,
   input  st_adapt_pkg::beat_t    in_data,
   input  logic                   in_startofpacket,
   input  logic                   in_endofpacket,
   input  st_adapt_pkg::in_empty_t in_empty,
   input  logic                   in_error,
   // from half select
   input  logic                   beat_done,
   // held beat
   output logic                   held_valid,
   output st_adapt_pkg::beat_t    held_data,
   output logic                   held_sop,
   output logic                   held_eop,
   output st_adapt_pkg::in_empty_t held_empty,
   output logic                   held_error
);

   // free slot, or the current beat leaves this cycle
   assign in_ready = beat_done | ~held_valid;

   //-----------------------------------------------------------------------
   // valid and packet markers
   //-----------------------------------------------------------------------

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         held_valid <= 1'b0;
         held_sop   <= 1'b0;
         held_eop   <= 1'b0;
         held_empty <= '0;
         held_error <= 1'b0;
      end else if (in_ready) begin
         // idle input simply empties the slot
         held_valid <= in_valid;
         held_sop   <= in_startofpacket;
         held_eop   <= in_endofpacket;
         held_error <= in_error;
         // empty only counts on an end of packet
         if (in_endofpacket) begin
            held_empty <= in_empty;
         end else begin
            held_empty <= '0;
         end
      end
   end

   // payload bytes
   always_ff @(posedge clk) begin
      if (in_ready) begin
         held_data <= in_data;
      end
   end

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------

   // half select may only retire a beat that is actually held
   a_done_needs_beat : assert property (
      @(posedge clk) disable iff (!reset_n)
      beat_done |-> held_valid
   );

endmodule

/* st_tx_64_to_32/st_half_select.sv */
//--------------------------------------------------------------------------
// half-select FSM of the 64 to 32 bit adapter
// splits the held beat into upper and lower words with eop and empty
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module st_half_select (
   input  logic                    clk,
   input  logic                    reset_n,
   // held beat from the input stage
   input  logic                    held_valid,
   input  st_adapt_pkg::beat_t     held_data,
   input  logic                    held_sop,
   input  logic                    held_eop,
   input  st_adapt_pkg::in_empty_t held_empty,
   input  logic                    held_error,
   // output register can take a word
   input  logic                    load_ok,
   output logic                    beat_done,
   // next word for the output stage
   output logic                    word_valid,
   output st_adapt_pkg::word_t     word_data,
   output logic                    word_sop,
   output logic                    word_eop,
   output st_adapt_pkg::out_empty_t word_empty,
   output logic                    word_error
);

   st_adapt_pkg::half_e state;
   st_adapt_pkg::half_e state_nxt;

   // a word moves on to the output register this cycle
   logic advance;
   // last beat short enough to end on the upper word
   logic short_last;

   assign advance = load_ok & held_valid;
   assign short_last = held_eop & (held_empty >= st_adapt_pkg::HALF_BYTES);

   //-----------------------------------------------------------------------
   // state register
   //-----------------------------------------------------------------------

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= st_adapt_pkg::HALF_UPPER;
      end else begin
         state <= state_nxt;
      end
   end

   //-----------------------------------------------------------------------
   // word select and next state
   //-----------------------------------------------------------------------

   always_comb begin
      state_nxt  = state;
      beat_done  = 1'b0;
      word_sop   = 1'b0;
      word_eop   = 1'b0;
      word_empty = '0;
      // big-endian, first byte sits in the top lane
      word_data  = held_data[st_adapt_pkg::IN_W-1 -: st_adapt_pkg::OUT_W];

      case (state)
         st_adapt_pkg::HALF_UPPER: begin
            // sop belongs to the first word only
            word_sop = held_valid & held_sop;
            if (short_last) begin
               word_eop = held_valid;
               // four or more spare bytes, drop the lower word entirely
               word_empty = st_adapt_pkg::out_empty_t'(
                  held_empty - st_adapt_pkg::in_empty_t'(st_adapt_pkg::HALF_BYTES));
            end
            if (advance) begin
               if (short_last) begin
                  beat_done = 1'b1;
               end else begin
                  state_nxt = st_adapt_pkg::HALF_LOWER;
               end
            end
         end

         st_adapt_pkg::HALF_LOWER: begin
            word_data = held_data[st_adapt_pkg::OUT_W-1:0];
            if (held_eop) begin
               word_eop = held_valid;
               // fewer than four spare bytes, count fits in two bits
               word_empty = held_empty[st_adapt_pkg::OUT_EMPTY_W-1:0];
            end
            if (advance) begin
               beat_done = 1'b1;
               state_nxt = st_adapt_pkg::HALF_UPPER;
            end
         end

         default: begin
            state_nxt = st_adapt_pkg::HALF_UPPER;
         end
      endcase
   end

   // output stage decides when it actually loads
   assign word_valid = held_valid;
   // error rides on every word of the beat
   assign word_error = held_error;

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------

   a_empty_only_on_eop : assert property (
      @(posedge clk) disable iff (!reset_n)
      (word_valid && (word_empty != '0)) |-> word_eop
   );

endmodule

/* st_tx_64_to_32/st_out_stage.sv */
//--------------------------------------------------------------------------
// output register stage of the 64 to 32 bit adapter
// ready/valid source for 32-bit words, holds under back-pressure
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module st_out_stage (
   input  logic                     clk,
   input  logic                     reset_n,
   // word from half select
   input  logic                     word_valid,
   input  st_adapt_pkg::word_t      word_data,
   input  logic                     word_sop,
   input  logic                     word_eop,
   input  st_adapt_pkg::out_empty_t word_empty,
   input  logic                     word_error,
   output logic                     load_ok,
   // downstream streaming side
   input  logic                     out_ready,
   output logic                     out_valid,
   output st_adapt_pkg::word_t      out_data,
   output logic                     out_startofpacket,
   output logic                     out_endofpacket,
   output st_adapt_pkg::out_empty_t out_empty,
   output logic                     out_error
);

   // sink takes the current word, or nothing is held
   assign load_ok = out_ready | ~out_valid;

   //-----------------------------------------------------------------------
   // output registers
   //-----------------------------------------------------------------------

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         out_valid         <= 1'b0;
         out_startofpacket <= 1'b0;
         out_endofpacket   <= 1'b0;
         out_empty         <= '0;
         out_error         <= 1'b0;
      end else if (load_ok) begin
         out_valid         <= word_valid;
         out_startofpacket <= word_sop;
         out_endofpacket   <= word_eop;
         out_empty         <= word_empty;
         out_error         <= word_error;
      end
   end

   // data lanes
   always_ff @(posedge clk) begin
      if (load_ok) begin
         out_data <= word_data;
      end
   end

   //-----------------------------------------------------------------------
   // checks
   //-----------------------------------------------------------------------

   // stalled word stays put until the sink takes it
   a_hold_on_stall : assert property (
      @(posedge clk) disable iff (!reset_n)
      (out_valid && !out_ready) |=>
         (out_valid && $stable(out_data) && $stable(out_startofpacket) &&
          $stable(out_endofpacket) && $stable(out_empty) && $stable(out_error))
   );

endmodule

/* st_tx_64_to_32/st_tx_64_to_32.sv */
//--------------------------------------------------------------------------
// transmit streaming width adapter, 64-bit beats in, 32-bit words out
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module st_tx_64_to_32 (
   input  logic                     clk,
   input  logic                     reset_n,
   // 64-bit sink
   input  logic                     in_valid,
   output logic                     in_ready,
   input  st_adapt_pkg::beat_t      in_data,
   input  logic                     in_startofpacket,
   input  logic                     in_endofpacket,
   input  st_adapt_pkg::in_empty_t  in_empty,
   input  logic                     in_error,
   // 32-bit source
   input  logic                     out_ready,
   output logic                     out_valid,
   output st_adapt_pkg::word_t      out_data,
   output logic                     out_startofpacket,
   output logic                     out_endofpacket,
   output st_adapt_pkg::out_empty_t out_empty,
   output logic                     out_error
);

   // held beat
   logic                     held_valid;
   st_adapt_pkg::beat_t      held_data;
   logic                     held_sop;
   logic                     held_eop;
   st_adapt_pkg::in_empty_t  held_empty;
   logic                     held_error;
   logic                     beat_done;

   // selected word
   logic                     word_valid;
   st_adapt_pkg::word_t      word_data;
   logic                     word_sop;
   logic                     word_eop;
   st_adapt_pkg::out_empty_t word_empty;
   logic                     word_error;
   logic                     load_ok;

   //-----------------------------------------------------------------------
   // stages
   //-----------------------------------------------------------------------

   st_in_stage u_in (
      .clk              (clk),
      .reset_n          (reset_n),
      .in_valid         (in_valid),
      .in_ready         (in_ready),
      .in_data          (in_data),
      .in_startofpacket (in_startofpacket),
      .in_endofpacket   (in_endofpacket),
      .in_empty         (in_empty),
      .in_error         (in_error),
      .beat_done        (beat_done),
      .held_valid       (held_valid),
      .held_data        (held_data),
      .held_sop         (held_sop),
      .held_eop         (held_eop),
      .held_empty       (held_empty),
      .held_error       (held_error)
   );

   st_half_select u_sel (
      .clk        (clk),
      .reset_n    (reset_n),
      .held_valid (held_valid),
      .held_data  (held_data),
      .held_sop   (held_sop),
      .held_eop   (held_eop),
      .held_empty (held_empty),
      .held_error (held_error),
      .load_ok    (load_ok),
      .beat_done  (beat_done),
      .word_valid (word_valid),
      .word_data  (word_data),
      .word_sop   (word_sop),
      .word_eop   (word_eop),
      .word_empty (word_empty),
      .word_error (word_error)
   );

   st_out_stage u_out (
      .clk               (clk),
      .reset_n           (reset_n),
      .word_valid        (word_valid),
      .word_data         (word_data),
      .word_sop          (word_sop),
      .word_eop          (word_eop),
      .word_empty        (word_empty),
      .word_error        (word_error),
      .load_ok           (load_ok),
      .out_ready         (out_ready),
      .out_valid         (out_valid),
      .out_data          (out_data),
      .out_startofpacket (out_startofpacket),
      .out_endofpacket   (out_endofpacket),
      .out_empty         (out_empty),
      .out_error         (out_error)
   );

endmodule

/* tests/tb_packet_table.svh */
//--------------------------------------------------------------------------
// packet table and xorshift generator for the 64 to 32 adapter testbench
//--------------------------------------------------------------------------

`ifndef TB_PACKET_TABLE_SVH
`define TB_PACKET_TABLE_SVH

localparam int NUM_PKTS = 16;

// one column per row of the table, index is the test number
// length in bytes
localparam int PKT_LEN [NUM_PKTS] =
   '{1, 4, 5, 8, 9, 12, 13, 16, 19, 23, 30, 40, 33, 27, 2, 38};
// error flag on every beat
localparam int PKT_ERR [NUM_PKTS] =
   '{0, 0, 1, 0, 0, 1, 0, 0, 0, 1, 0, 0, 1, 0, 0, 1};
// sink stall percentage
localparam int PKT_STALL [NUM_PKTS] =
   '{0, 0, 0, 0, 0, 0, 0, 0, 20, 40, 50, 30, 50, 40, 25, 50};
// expected 32-bit words per packet
localparam int PKT_WORDS [NUM_PKTS] =
   '{1, 1, 2, 2, 3, 3, 4, 4, 5, 6, 8, 10, 9, 7, 1, 10};
// expected out_empty on the last word
localparam int PKT_LAST_EMPTY [NUM_PKTS] =
   '{3, 0, 3, 0, 3, 0, 3, 0, 1, 1, 2, 0, 3, 1, 2, 2};

// 32-bit xorshift, 13 / 17 / 5
function automatic bit [31:0] xorshift32(input bit [31:0] x);
   bit [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

`endif

/* tests/tb_st_tx_64_to_32.sv */
//--------------------------------------------------------------------------
// testbench for the 64 to 32 bit transmit adapter
// table driven packets, word scoreboard, random sink stalls
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_st_tx_64_to_32;

   logic                     clk;
   logic                     reset_n;
   logic                     in_valid;
   logic                     in_ready;
   st_adapt_pkg::beat_t      in_data;
   logic                     in_startofpacket;
   logic                     in_endofpacket;
   st_adapt_pkg::in_empty_t  in_empty;
   logic                     in_error;
   logic                     out_ready;
   logic                     out_valid;
   st_adapt_pkg::word_t      out_data;
   logic                     out_startofpacket;
   logic                     out_endofpacket;
   st_adapt_pkg::out_empty_t out_empty;
   logic                     out_error;

   `include "tb_packet_table.svh"

   // scoreboard queues, one entry per expected word
   st_adapt_pkg::word_t      exp_data [$];
   st_adapt_pkg::out_empty_t exp_empty [$];
   bit                       exp_sop [$];
   bit                       exp_eop [$];
   bit                       exp_err [$];

   logic [7:0]               pkt [0:47];
   bit [31:0]                rng_data;
   bit [31:0]                rng_stall;
   int                       stall_pct;
   int                       cycle_count;
   int                       cycle_limit;
   int                       error_count;
   int                       pass_count;
   int                       fail_count;
   int                       words_seen;
   bit                       eop_seen;
   st_adapt_pkg::out_empty_t last_empty_seen;

   st_tx_64_to_32 u_dut (.*);

   always #5 clk = ~clk;

   //-----------------------------------------------------------------------
   // compare tasks
   //-----------------------------------------------------------------------

   task automatic compare_word(input string name, input st_adapt_pkg::word_t exp,
                               input st_adapt_pkg::word_t act);
      if (exp !== act) begin
         error_count++;
         $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_empty(input string name, input st_adapt_pkg::out_empty_t exp,
                              input st_adapt_pkg::out_empty_t act);
      if (exp !== act) begin
         error_count++;
         $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
      end
   endtask

   task automatic expect_flag(input string name, input bit exp, input bit act);
      if (exp !== act) begin
         error_count++;
         $display("ERR %0t %s expected %0b got %0b", $time, name, exp, act);
      end
   endtask

   //-----------------------------------------------------------------------
   // reference model and driver
   //-----------------------------------------------------------------------

   // words of the packet in pkt, upper half of each beat first
   task automatic build_expected(input int len, input bit err);
      int nbeats;
      int e;
      int base;
      bit last_word;
      nbeats = (len + 7) / 8;
      e = nbeats * 8 - len;
      for (int b = 0; b < nbeats; b++) begin
         for (int h = 0; h < 2; h++) begin
            // short last beat has no lower word
            if (!(h == 1 && b == nbeats - 1 && e >= st_adapt_pkg::HALF_BYTES)) begin
               base = b * 8 + h * 4;
               last_word = (b == nbeats - 1) && (h == 1 || e >= st_adapt_pkg::HALF_BYTES);
               exp_data.push_back({pkt[base], pkt[base+1], pkt[base+2], pkt[base+3]});
               exp_sop.push_back(b == 0 && h == 0);
               exp_eop.push_back(last_word);
               exp_err.push_back(err);
               if (!last_word) begin
                  exp_empty.push_back('0);
               end else if (e >= st_adapt_pkg::HALF_BYTES) begin
                  exp_empty.push_back(st_adapt_pkg::out_empty_t'(e - st_adapt_pkg::HALF_BYTES));
               end else begin
                  exp_empty.push_back(st_adapt_pkg::out_empty_t'(e));
               end
            end
         end
      end
   endtask

   task automatic drive_packet(input int len, input bit err);
      int nbeats;
      int e;
      st_adapt_pkg::beat_t beat;
      nbeats = (len + 7) / 8;
      e = nbeats * 8 - len;
      for (int b = 0; b < nbeats; b++) begin
         // first byte in the top lane
         for (int k = 0; k < 8; k++) begin
            beat = {beat[55:0], pkt[b*8+k]};
         end
         @(posedge clk);
         #1;
         in_valid         = 1'b1;
         in_data          = beat;
         in_startofpacket = (b == 0);
         in_endofpacket   = (b == nbeats - 1);
         in_empty         = (b == nbeats - 1) ? st_adapt_pkg::in_empty_t'(e) : '0;
         in_error         = err;
         // beat moves at the edge after a ready negedge
         @(negedge clk);
         while (!in_ready) begin
            @(negedge clk);
         end
      end
      @(posedge clk);
      #1;
      in_valid         = 1'b0;
      in_startofpacket = 1'b0;
      in_endofpacket   = 1'b0;
      in_empty         = '0;
      in_error         = 1'b0;
   endtask

   //-----------------------------------------------------------------------
   // sink, monitor, timeout
   //-----------------------------------------------------------------------

   always @(posedge clk) begin
      #1;
      rng_stall = xorshift32(rng_stall);
      out_ready = (rng_stall % 100) >= stall_pct;
   end

   // handshake is settled at the negedge, word moves on the next edge
   always @(negedge clk) begin
      if (reset_n && out_valid && out_ready) begin
         words_seen++;
         if (exp_data.size() == 0) begin
            error_count++;
            $display("output word %h arrived with no word expected at %0t", out_data, $time);
         end else begin
            compare_word("out_data", exp_data.pop_front(), out_data);
            check_empty("out_empty", exp_empty.pop_front(), out_empty);
            expect_flag("out_startofpacket", exp_sop.pop_front(), out_startofpacket);
            expect_flag("out_endofpacket", exp_eop.pop_front(), out_endofpacket);
            expect_flag("out_error", exp_err.pop_front(), out_error);
         end
         // packet ends where the DUT marks it
         if (out_endofpacket) begin
            last_empty_seen = out_empty;
            eop_seen = 1'b1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles with %0d words still missing",
                  cycle_count, exp_data.size());
         $display("Test FAILED");
         $finish;
      end
   end

   //-----------------------------------------------------------------------
   // main sequence
   //-----------------------------------------------------------------------

   initial begin
      int errs_before;
      int total_words;
      clk = 1'b0;
      reset_n = 1'b0;
      in_valid = 1'b0;
      in_data = '0;
      in_startofpacket = 1'b0;
      in_endofpacket = 1'b0;
      in_empty = '0;
      in_error = 1'b0;
      out_ready = 1'b1;
      rng_data = 32'h747f;
      rng_stall = 32'h747f;
      stall_pct = 0;
      cycle_count = 0;
      error_count = 0;
      pass_count = 0;
      fail_count = 0;
      words_seen = 0;
      eop_seen = 1'b0;
      last_empty_seen = '0;
      total_words = 0;
      for (int i = 0; i < NUM_PKTS; i++) begin
         total_words += PKT_WORDS[i];
      end
      cycle_limit = 4 * total_words + 100;

      repeat (8) @(posedge clk);
      #1;
      reset_n = 1'b1;

      // idle state right after reset
      @(negedge clk);
      errs_before = error_count;
      expect_flag("out_valid", 1'b0, out_valid);
      expect_flag("in_ready", 1'b1, in_ready);
      if (error_count == errs_before) begin
         pass_count++;
         $display("test reset: pass");
      end else begin
         fail_count++;
         $display("test reset: fail");
      end

      for (int i = 0; i < NUM_PKTS; i++) begin
         errs_before = error_count;
         for (int k = 0; k < 48; k++) begin
            if (k < PKT_LEN[i]) begin
               rng_data = xorshift32(rng_data);
               pkt[k] = rng_data[7:0];
            end else begin
               pkt[k] = 8'h00;
            end
         end
         stall_pct = PKT_STALL[i];
         words_seen = 0;
         eop_seen = 1'b0;
         build_expected(PKT_LEN[i], PKT_ERR[i] != 0);
         drive_packet(PKT_LEN[i], PKT_ERR[i] != 0);
         while (!eop_seen) begin
            @(negedge clk);
         end
         if (words_seen != PKT_WORDS[i]) begin
            error_count++;
            $display("ERR %0t word count expected %0d got %0d", $time,
                     PKT_WORDS[i], words_seen);
         end
         check_empty("last out_empty", st_adapt_pkg::out_empty_t'(PKT_LAST_EMPTY[i]),
                     last_empty_seen);
         // words still owed by a packet that ended early
         exp_data.delete();
         exp_empty.delete();
         exp_sop.delete();
         exp_eop.delete();
         exp_err.delete();
         if (error_count == errs_before) begin
            pass_count++;
            $display("test %0d len %0d stall %0d: pass", i, PKT_LEN[i], PKT_STALL[i]);
         end else begin
            fail_count++;
            $display("test %0d len %0d stall %0d: fail", i, PKT_LEN[i], PKT_STALL[i]);
         end
      end

      // stray words would show up here
      stall_pct = 0;
      repeat (10) @(posedge clk);
      $display("passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0 && error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* st_tx_64_to_32.f */
+incdir+tests
common/st_adapt_pkg.sv
st_tx_64_to_32/st_in_stage.sv
st_tx_64_to_32/st_half_select.sv
st_tx_64_to_32/st_out_stage.sv
st_tx_64_to_32/st_tx_64_to_32.sv
tests/tb_st_tx_64_to_32.sv

/* run_sim.sh */
#!/bin/sh
# build and run the st_tx_64_to_32 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_st_tx_64_to_32

verilator --binary --timing --assert -Wno-fatal \
   -f st_tx_64_to_32.f \
   --top-module "$TOP" \
   -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
if ! grep -q "Test OK" "$LOG"; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
